//--- verilog/scan_pkg.sv
// Packet side types shared by the scanner blocks
package scan_pkg;

  // Stream id width and number of tracked flows
  localparam int FLOW_W = 6;
  localparam int FLOW_NUM = 1 << FLOW_W;

  // Payload byte width
  localparam int BYTE_W = 8;

  // Width of the matched packet counter
  localparam int COUNT_W = 16;

  // Stream id of one flow
  typedef logic [FLOW_W-1:0] flow_id_t;

  // One payload byte with its strobe
  typedef struct packed {
    logic              vld;
    logic [BYTE_W-1:0] data;
  } char_beat_t;

  // Packet delimiters
  // Id is only meaningful together with sop
  typedef struct packed {
    logic     sop;
    logic     eop;
    flow_id_t id;
  } pkt_ctrl_t;

  // Config write to the per-flow enable table
  typedef struct packed {
    logic     wr;
    flow_id_t id;
    logic     en;
  } cfg_wr_t;

endpackage

//--- verilog/dfa_pkg.sv
// Pattern and state definitions of the HTTP matcher
package dfa_pkg;

  // Encoded state width
  localparam int STATE_W = 3;

  // Number of bytes in the pattern
  localparam int ACCEPT_LEN = 5;

  // Pattern text, first byte in the top bits
  localparam logic [ACCEPT_LEN*8-1:0] PATTERN = "HTTP/";

  // Prefix states, one per matched prefix length
  // S_P means "HTTP" seen and waiting for the slash
  typedef enum logic [STATE_W-1:0] {
    S_IDLE = 3'd0,
    S_H    = 3'd1,
    S_HT   = 3'd2,
    S_HTT  = 3'd3,
    S_P    = 3'd4
  } state_t;

endpackage

//--- verilog/http_dfa.sv
`timescale 1ns/1ps

module http_dfa (
  input  logic                clk,
  input  logic                rst_n,
  input  scan_pkg::char_beat_t char_in,
  input  dfa_pkg::state_t     state_in,
  input  logic                state_in_vld,
  output dfa_pkg::state_t     state_out,
  output logic                accept_out
);

  // Byte expected in the current state and the pattern's first byte
  logic [7:0]      exp_byte;
  logic [7:0]      first_byte;
  // Index of the expected byte counted from the pattern start
  int              idx;
  // Next state and hit for the current byte
  dfa_pkg::state_t nxt_state;
  logic            hit;

  assign first_byte = dfa_pkg::PATTERN[dfa_pkg::ACCEPT_LEN*8-1 -: 8];

  // KMP step
  // H only occurs at the pattern start, so every failure link
  // goes to S_H on an H and to S_IDLE otherwise
  always_comb
  begin
    idx = int'(state_out);
    exp_byte = dfa_pkg::PATTERN[8 * (dfa_pkg::ACCEPT_LEN - 1 - idx) +: 8];
    hit = 1'b0;
    nxt_state = dfa_pkg::S_IDLE;
    if (char_in.data == exp_byte)
    begin
      if (state_out == dfa_pkg::S_P)
      begin
        // Slash after HTTP completes the pattern
        hit = 1'b1;
        nxt_state = dfa_pkg::S_IDLE;
      end
      else
      begin
        nxt_state = dfa_pkg::state_t'(state_out + 3'd1);
      end
    end
    else if (char_in.data == first_byte)
    begin
      nxt_state = dfa_pkg::S_H;
    end
  end

  // State register
  // A restore from the context side wins over a byte
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_out <= dfa_pkg::S_IDLE;
      accept_out <= 1'b0;
    end
    else if (state_in_vld)
    begin
      state_out <= state_in;
      accept_out <= 1'b0;
    end
    else if (char_in.vld)
    begin
      state_out <= nxt_state;
      accept_out <= hit;
    end
    else
    begin
      // Accept is a single cycle pulse
      accept_out <= 1'b0;
    end
  end

endmodule

//--- verilog/flow_table.sv
`timescale 1ns/1ps

module flow_table (
  input  logic                clk,
  input  logic                rst_n,
  input  scan_pkg::pkt_ctrl_t pkt,
  input  scan_pkg::cfg_wr_t   cfg,
  output logic                load,
  output scan_pkg::flow_id_t  flow_id,
  output logic                new_flow,
  output logic                flow_en
);

  // One bit per flow
  // Known means a state has been or will be saved for the flow
  logic [scan_pkg::FLOW_NUM-1:0] known_r;
  // Enable bits written by config
  logic [scan_pkg::FLOW_NUM-1:0] en_r;

  // Control state and per-flow bits
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      known_r <= '0;
      en_r <= '0;
      load <= 1'b0;
      new_flow <= 1'b0;
      flow_en <= 1'b0;
    end
    else
    begin
      // Load follows sop by one cycle
      load <= pkt.sop;

      // Config write, seen by packets starting a cycle later
      if (cfg.wr)
      begin
        en_r[cfg.id] <= cfg.en;
      end

      if (pkt.sop)
      begin
        new_flow <= !known_r[pkt.id];
        flow_en <= en_r[pkt.id];
        // A disabled packet saves nothing, so the flow stays new
        if (en_r[pkt.id])
        begin
          known_r[pkt.id] <= 1'b1;
        end
      end
    end
  end

  // Packet flow id held until the next sop
  always_ff @(posedge clk)
  begin
    if (pkt.sop)
    begin
      flow_id <= pkt.id;
    end
  end

endmodule

//--- verilog/regex_flow_ctx.sv
`timescale 1ns/1ps

module regex_flow_ctx (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        load,
  input  logic                        new_flow,
  input  logic                        flow_en,
  input  logic                        eop,
  input  scan_pkg::flow_id_t          flow_id,
  input  scan_pkg::char_beat_t        beat,
  input  dfa_pkg::state_t             dfa_state,
  input  logic                        dfa_accept,
  output scan_pkg::char_beat_t        char_r,
  output dfa_pkg::state_t             state_in,
  output logic                        state_in_vld,
  output logic [scan_pkg::COUNT_W-1:0] count,
  output logic                        fired
);

  // Saved DFA state per flow
  dfa_pkg::state_t state_mem [scan_pkg::FLOW_NUM];

  // Restored state, one cycle after load
  dfa_pkg::state_t    rd_state;
  logic               rd_vld;
  // DFA outputs registered once
  dfa_pkg::state_t    state_out_r;
  logic               accept_r;
  // Current packet flow and enable
  scan_pkg::flow_id_t pkt_id_r;
  logic               pkt_en_r;
  // At least one match in this packet
  logic               match_r;

  // Fired shows the registered accept before the flag catches it
  assign fired = match_r | accept_r;

  // Restore path
  // New flows start from idle, known flows from memory
  always_ff @(posedge clk)
  begin
    if (load)
    begin
      rd_state <= new_flow ? dfa_pkg::S_IDLE : state_mem[flow_id];
      pkt_id_r <= flow_id;
    end
  end

  // Save path, only for enabled packets
  always_ff @(posedge clk)
  begin
    if (eop && pkt_en_r)
    begin
      state_mem[pkt_id_r] <= state_out_r;
    end
  end

  // DFA payload registers in both directions
  always_ff @(posedge clk)
  begin
    state_in <= rd_state;
    state_out_r <= dfa_state;
  end

  // Strobes, counters and flags
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      char_r <= '0;
      rd_vld <= 1'b0;
      state_in_vld <= 1'b0;
      accept_r <= 1'b0;
      pkt_en_r <= 1'b0;
      match_r <= 1'b0;
      count <= '0;
    end
    else
    begin
      char_r <= beat;
      rd_vld <= load;
      state_in_vld <= rd_vld;
      accept_r <= dfa_accept;

      if (load)
      begin
        pkt_en_r <= flow_en;
        // New packet starts without a match
        match_r <= 1'b0;
      end

      // Any number of matches counts once
      if (accept_r)
      begin
        match_r <= 1'b1;
      end

      if (eop)
      begin
        if (pkt_en_r)
        begin
          count <= count + scan_pkg::COUNT_W'(match_r);
        end
        else
        begin
          // Disabled packet drops its result
          match_r <= 1'b0;
        end
      end
    end
  end

endmodule

//--- verilog/scan_top.sv
`timescale 1ns/1ps

module scan_top (
  input  logic                        clk,
  input  logic                        rst_n,
  input  scan_pkg::pkt_ctrl_t         pkt,
  input  scan_pkg::char_beat_t        beat,
  input  scan_pkg::cfg_wr_t           cfg,
  output logic [scan_pkg::COUNT_W-1:0] count,
  output logic                        fired
);

  // Flow table to context
  logic                 load;
  scan_pkg::flow_id_t   flow_id;
  logic                 new_flow;
  logic                 flow_en;
  // Context to DFA and back
  scan_pkg::char_beat_t char_r;
  dfa_pkg::state_t      state_in;
  logic                 state_in_vld;
  dfa_pkg::state_t      state_out;
  logic                 accept_out;

  // Flow lookup at sop
  flow_table flow_table_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .pkt      (pkt),
    .cfg      (cfg),
    .load     (load),
    .flow_id  (flow_id),
    .new_flow (new_flow),
    .flow_en  (flow_en)
  );

  // Save, restore and counting
  regex_flow_ctx regex_flow_ctx_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .load         (load),
    .new_flow     (new_flow),
    .flow_en      (flow_en),
    .eop          (pkt.eop),
    .flow_id      (flow_id),
    .beat         (beat),
    .dfa_state    (state_out),
    .dfa_accept   (accept_out),
    .char_r       (char_r),
    .state_in     (state_in),
    .state_in_vld (state_in_vld),
    .count        (count),
    .fired        (fired)
  );

  // Pattern matcher
  http_dfa http_dfa_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .char_in      (char_r),
    .state_in     (state_in),
    .state_in_vld (state_in_vld),
    .state_out    (state_out),
    .accept_out   (accept_out)
  );

endmodule

//--- verif/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  input  logic rst_req,
  output logic clk,
  output logic rst_n
);

  // Power-on part of the reset
  logic por_n;

  // 20 ns period
  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Reset low for the first 8 rising edges, released on a falling edge
  initial
  begin
    por_n = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    por_n = 1'b1;
  end

  // Testbench can pull reset again in the middle of a run
  assign rst_n = por_n & ~rst_req;

endmodule

//--- verif/tb_scan.sv
`timescale 1ns/1ps

module tb_scan;

  // Watchdog budget in clock cycles
  localparam int CYC_PER_REC = 200;
  localparam int CYC_BASE = 1000;
  // Record letters c, p and r, plus the comment mark
  localparam int KIND_CFG = 99;
  localparam int KIND_PKT = 112;
  localparam int KIND_RST = 114;
  localparam int CH_HASH = 35;
  localparam int CH_NL = 10;

  logic                         clk;
  logic                         rst_n;
  logic                         rst_req;
  scan_pkg::pkt_ctrl_t          pkt;
  scan_pkg::char_beat_t         beat;
  scan_pkg::cfg_wr_t            cfg;
  logic [scan_pkg::COUNT_W-1:0] count;
  logic                         fired;

  integer seed;
  int     fd;
  // Records read so far, scales the watchdog
  int     rec_cnt;

  tb_clk_gen i_clk_gen (
    .rst_req (rst_req),
    .clk     (clk),
    .rst_n   (rst_n)
  );

  scan_top i_dut (
    .clk   (clk),
    .rst_n (rst_n),
    .pkt   (pkt),
    .beat  (beat),
    .cfg   (cfg),
    .count (count),
    .fired (fired)
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
      fail_run($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // Extra idle cycles, 0 to 3
  function automatic int random_gap();
    return $random(seed) & 3;
  endfunction

  // Next record letter, skips blanks and comments, -1 at end of file
  function automatic int next_kind();
    int ch;
    ch = $fgetc(fd);
    while ((ch >= 0 && ch <= 32) || ch == CH_HASH)
    begin
      if (ch == CH_HASH)
        while (ch != CH_NL && ch != -1)
          ch = $fgetc(fd);
      ch = $fgetc(fd);
    end
    return ch;
  endfunction

  // Enable write, seen by a sop one cycle later
  task automatic write_cfg(input int flow, input int en);
    cfg.wr = 1'b1;
    cfg.id = scan_pkg::flow_id_t'(flow);
    cfg.en = 1'(en);
    @(negedge clk);
    cfg = '0;
  endtask

  // Mid-run reset, then back to the reset values
  task automatic pulse_reset();
    rst_req = 1'b1;
    idle_cycles(8);
    rst_req = 1'b0;
    @(negedge clk);
    check_value("count", 32'(count), 0);
    check_value("fired", 32'(fired), 0);
  endtask

  task automatic send_packet(input int flow, input logic [7:0] data [$],
                             input int exp_pre, input int exp_cnt, input int exp_post);
    pkt.sop = 1'b1;
    pkt.id = scan_pkg::flow_id_t'(flow);
    @(negedge clk);
    pkt.sop = 1'b0;
    // Restore path needs 4 cycles before the first byte
    idle_cycles(3 + random_gap());
    foreach (data[i])
    begin
      beat.vld = 1'b1;
      beat.data = data[i];
      @(negedge clk);
      beat = '0;
      idle_cycles(random_gap());
    end
    // Accept reaches the flag 3 cycles after the last byte
    idle_cycles(3 + random_gap());
    check_value("fired before eop", 32'(fired), exp_pre);
    pkt.eop = 1'b1;
    @(negedge clk);
    pkt.eop = 1'b0;
    check_value("count", 32'(count), exp_cnt);
    check_value("fired after eop", 32'(fired), exp_post);
    // At least 2 cycles from eop to the next sop
    idle_cycles(1 + random_gap());
  endtask

  // Watchdog, budget grows with the records read
  initial
  begin
    int cyc;
    cyc = 0;
    while (cyc <= CYC_PER_REC * rec_cnt + CYC_BASE)
    begin
      @(posedge clk);
      cyc++;
    end
    $display("Timeout, the run took longer than its records allow");
    $display("Test FAILED");
    $fatal(1, "Simulation stopped");
  end

  initial
  begin
    int         kind;
    int         rc;
    int         flow;
    int         en;
    int         n;
    int         b;
    int         exp_pre;
    int         exp_cnt;
    int         exp_post;
    logic [7:0] data [$];
    seed = 32'h59ee_7f16;
    rec_cnt = 0;
    rst_req = 1'b0;
    pkt = '0;
    beat = '0;
    cfg = '0;
    fd = $fopen("verif/scan_cases.txt", "r");
    if (fd == 0)
      fail_run("Cannot open the cases file verif/scan_cases.txt");
    wait (rst_n);
    @(negedge clk);
    // Values straight after reset
    check_value("count", 32'(count), 0);
    check_value("fired", 32'(fired), 0);
    kind = next_kind();
    while (kind != -1)
    begin
      rec_cnt++;
      if (kind == KIND_CFG)
      begin
        rc = $fscanf(fd, "%d %d", flow, en);
        if (rc != 2)
          fail_run("The cases file has a config record with missing fields");
        write_cfg(flow, en);
      end
      else if (kind == KIND_RST)
      begin
        pulse_reset();
      end
      else if (kind == KIND_PKT)
      begin
        rc = $fscanf(fd, "%d %d", flow, n);
        if (rc != 2 || n < 1)
          fail_run("The cases file has a packet record with a bad header");
        data.delete();
        repeat (n)
        begin
          rc = $fscanf(fd, "%h", b);
          if (rc != 1)
            fail_run("The cases file has a packet record with too few bytes");
          data.push_back(8'(b));
        end
        rc = $fscanf(fd, "%d %d %d", exp_pre, exp_cnt, exp_post);
        if (rc != 3)
          fail_run("The cases file has a packet record without expected values");
        send_packet(flow, data, exp_pre, exp_cnt, exp_post);
      end
      else
      begin
        fail_run("The cases file has a record of unknown kind");
      end
      kind = next_kind();
    end
    $fclose(fd);
    $display("Test OK");
    $finish;
  end

endmodule

//--- verif/scan_cases.txt
# c <flow> <en> | r for reset | p <flow> <nbytes> <hex bytes> <fired pre-eop> <count> <fired post-eop>
# HTTP/ is 48 54 54 50 2f, count is the total after the packet's eop
c 5 1
c 9 1
# One match, then two matches counted once
p 5 7 41 48 54 54 50 2f 42 1 1 1
p 9 10 48 54 54 50 2f 48 54 54 50 2f 1 2 1
# HT ends flow 5, flow 9 in between, TP/ starts the next flow 5 packet
p 5 3 20 48 54 0 2 0
p 9 3 54 50 2f 0 2 0
p 5 4 54 50 2f 41 1 3 1
# Disabled flow fires without counting
p 7 5 48 54 54 50 2f 1 3 0
# Disabled packet in the middle of a split match leaves the saved state
c 3 1
p 3 2 48 54 0 3 0
c 3 0
p 3 2 54 50 0 3 0
c 3 1
p 3 1 2f 0 3 0
# Flow 12 saves HTTP, after reset it starts from idle
c 12 1
p 12 5 41 48 54 54 50 0 3 0
r
c 12 1
p 12 1 2f 0 0 0
# Mix over flows 1 2 4 and disabled flow 6
c 1 1
c 2 1
c 4 1
p 1 2 48 54 0 0 0
p 2 5 48 54 54 50 2f 1 1 1
p 4 2 41 48 0 1 0
p 1 2 54 50 0 1 0
p 6 6 48 54 54 50 2f 41 1 1 0
p 4 4 54 54 50 2f 1 2 1
p 1 2 2f 48 1 3 1
p 2 3 48 48 54 0 3 0
p 6 3 54 50 2f 0 3 0
p 2 8 54 50 2f 48 54 54 50 2f 1 4 1
p 1 3 54 54 50 0 4 0
p 4 2 50 2f 0 4 0
p 1 2 50 2f 0 4 0
p 6 2 48 54 0 4 0
p 4 4 48 54 54 50 0 4 0
p 2 3 41 42 43 0 4 0
p 4 1 2f 1 5 1
p 6 3 54 50 2f 0 5 0
p 1 10 48 54 54 50 2f 48 54 54 50 2f 1 6 1
p 2 3 48 54 54 0 6 0

//--- compile.f
verilog/scan_pkg.sv
verilog/dfa_pkg.sv
verilog/http_dfa.sv
verilog/flow_table.sv
verilog/regex_flow_ctx.sv
verilog/scan_top.sv
verif/tb_clk_gen.sv
verif/tb_scan.sv

//--- run.sh
#!/usr/bin/env bash
# Build the scanner testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_scan -f compile.f

# A fatal stop returns non-zero, the search below decides the result
out=$(./obj_dir/Vtb_scan 2>&1 || true)
echo "$out"

grep -qx "Test OK" <<< "$out"
